//--- bench/fetch_clock.sv
module fetch_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk; // period 100
		end
	end

endmodule

//--- bench/fetch_properties.sv
module fetch_properties (
	input logic       clk,
	input logic       rst,
	input logic       wb_ack,
	input logic       f_valid,
	input logic [2:0] stat
);

	import y86_pkg::*;

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else $error("wb_ack high two cycles in a row");

	no_valid_in_reset: assert property (@(posedge clk) rst |-> !f_valid)
		else $error("f_valid high during reset");

	// stopped status is sticky
	stat_held: assert property (@(posedge clk) disable iff (rst)
		(!f_valid && stat != STAT_AOK) |=> (stat == $past(stat)))
		else $error("stopped status changed before reset");

endmodule

bind y86_fetch_top fetch_properties u_props (
	.clk(clk),
	.rst(rst),
	.wb_ack(wb_ack),
	.f_valid(f_valid),
	.stat(stat)
);

//--- bench/fetch_ref.svh
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// irmovq rrmovq addq pushq popq rmmovq mrmovq nop halt
// nop sits at 38, halt at 39
localparam logic [7:0] STRAIGHT_PROG [40] = '{
	8'h30, 8'hF0, 8'h88, 8'h77, 8'h66, 8'h55, 8'h44, 8'h33, 8'h22, 8'h11,
	8'h20, 8'h03,
	8'h60, 8'h31,
	8'hA0, 8'h1F,
	8'hB0, 8'h2F,
	8'h40, 8'h24, 8'h10, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h50, 8'h64, 8'h08, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h10,
	8'h00
};

// bytes past the end of memory read as zero
function automatic logic [7:0] img_byte(input logic [63:0] a);
	if (a < 64'(IMEM_BYTES)) begin
		return img[a[AW-1:0]];
	end
	return 8'h00;
endfunction

function automatic void ref_fetch(input logic [63:0] pc,
		output logic [3:0] e_icode, output logic [3:0] e_ifun,
		output logic [3:0] e_ra, output logic [3:0] e_rb,
		output logic [63:0] e_valc, output logic [63:0] e_valp,
		output logic [63:0] e_pred, output logic [2:0] e_stat);
	logic [7:0] b0;
	logic [7:0] rbyte;
	logic       regs;
	logic       cst;
	logic       ok;
	b0      = img_byte(pc);
	rbyte   = img_byte(pc + 64'd1);
	e_icode = b0[7:4];
	e_ifun  = b0[3:0];
	regs = (e_icode >= 4'h2 && e_icode <= 4'h6) || e_icode == 4'hA || e_icode == 4'hB;
	cst  = (e_icode >= 4'h3 && e_icode <= 4'h5) || e_icode == 4'h7 || e_icode == 4'h8;
	if (e_icode == 4'h6) begin
		ok = (e_ifun <= 4'h3);
	end else if (e_icode == 4'h2 || e_icode == 4'h7) begin
		ok = (e_ifun <= 4'h6); // cmov and jXX
	end else begin
		ok = (e_icode <= 4'hB) && (e_ifun == 4'h0);
	end
	e_ra   = regs ? rbyte[7:4] : 4'hF;
	e_rb   = regs ? rbyte[3:0] : 4'hF;
	e_valc = 64'd0;
	if (cst) begin
		for (int k = 0; k < 8; k++) begin
			e_valc[8*k +: 8] = img_byte(pc + (regs ? 64'd2 : 64'd1) + 64'(k));
		end
	end
	e_valp = pc + 64'd1 + 64'(regs) + (cst ? 64'd8 : 64'd0);
	e_pred = (e_icode == 4'h7 || e_icode == 4'h8) ? e_valc : e_valp;
	if (pc >= 64'(IMEM_BYTES)) begin
		e_stat = STAT_ADR;
	end else if (!ok) begin
		e_stat = STAT_INS;
	end else if (e_icode == 4'h0) begin
		e_stat = STAT_HLT;
	end else begin
		e_stat = STAT_AOK;
	end
endfunction

`endif

//--- bench/fetch_tb.sv
module fetch_tb;

	import y86_pkg::*;

	localparam int IMEM_BYTES = 256;
	localparam int AW = $clog2(IMEM_BYTES);
	// cycle budget of load and readback plus five short tests
	localparam int TEST_CYCLES = IMEM_BYTES * 8 + 5 * 400;

	logic          clk;
	logic          rst;
	logic          wb_cyc;
	logic          wb_stb;
	logic          wb_we;
	logic [AW-1:0] wb_adr;
	logic [7:0]    wb_dat_w;
	logic [7:0]    wb_dat_r;
	logic          wb_ack;
	logic          run;
	logic          stall;
	logic          redirect;
	logic [63:0]   redirect_pc;
	logic          f_valid;
	logic [63:0]   f_pc;
	logic [3:0]    icode;
	logic [3:0]    ifun;
	logic [3:0]    ra;
	logic [3:0]    rb;
	logic [63:0]   valc;
	logic [63:0]   valp;
	logic [2:0]    stat;

	logic [7:0]  img [IMEM_BYTES]; // own copy of the memory
	logic [63:0] exp_pc;
	logic [63:0] seen [$];
	logic [63:0] ref_seq [$];
	logic        hold_active;
	logic [63:0] held_pc;
	logic [63:0] held_valc;
	logic [63:0] held_valp;
	logic [3:0]  held_icode;
	logic        stall_en;
	int          errors;
	int          checks;
	int          accepted;
	int          tests_run;
	int          tests_failed;
	int          err_at_start;

	`include "fetch_ref.svh"

	fetch_clock u_clk (.clk(clk));

	y86_fetch_top #(.IMEM_BYTES(IMEM_BYTES)) DUT (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.run(run), .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.f_valid(f_valid), .f_pc(f_pc), .icode(icode), .ifun(ifun), .ra(ra), .rb(rb),
		.valc(valc), .valp(valp), .stat(stat)
	);

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// compares at each edge on values from before the edge
	always @(posedge clk) begin
		logic [3:0]  e_icode;
		logic [3:0]  e_ifun;
		logic [3:0]  e_ra;
		logic [3:0]  e_rb;
		logic [63:0] e_valc;
		logic [63:0] e_valp;
		logic [63:0] e_pred;
		logic [2:0]  e_stat;
		if (rst) begin
			exp_pc      <= 64'd0;
			hold_active <= 1'b0;
		end else begin
			if (hold_active) begin
				check("f_pc held", f_pc, held_pc);
				check("valc held", valc, held_valc);
				check("valp held", valp, held_valp);
				check("icode held", 64'(icode), 64'(held_icode));
			end
			hold_active <= f_valid && stall && !redirect;
			held_pc     <= f_pc;
			held_valc   <= valc;
			held_valp   <= valp;
			held_icode  <= icode;
			if (redirect) begin
				exp_pc <= redirect_pc;
			end else if (f_valid && !stall) begin
				ref_fetch(exp_pc, e_icode, e_ifun, e_ra, e_rb, e_valc, e_valp, e_pred, e_stat);
				check("f_pc", f_pc, exp_pc);
				check("icode", 64'(icode), 64'(e_icode));
				check("ifun", 64'(ifun), 64'(e_ifun));
				check("ra", 64'(ra), 64'(e_ra));
				check("rb", 64'(rb), 64'(e_rb));
				check("valc", valc, e_valc);
				check("valp", valp, e_valp);
				check("stat", 64'(stat), 64'(e_stat));
				seen.push_back(f_pc);
				accepted++;
				if (e_stat == STAT_AOK) begin
					exp_pc <= e_pred;
				end
			end
		end
	end

	// single access that expects ack to fall after one cycle
	task automatic wb_access(input logic we, input int a, input logic [7:0] d,
			output logic [7:0] q);
		int n;
		n = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= AW'(a);
		wb_dat_w <= d;
		do begin
			@(posedge clk);
			n++;
		end while (!wb_ack && n < 20);
		if (!wb_ack) begin
			errors++;
			$display("no wishbone ack within 20 cycles at address %h", a);
		end
		q = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(posedge clk);
		check("wb_ack", 64'(wb_ack), 64'd0);
	endtask

	task automatic put_byte(input int a, input logic [7:0] d);
		logic [7:0] q;
		wb_access(1'b1, a, d, q);
		img[AW'(a)] = d;
	endtask

	task automatic put_quad(input int a, input logic [63:0] v);
		for (int k = 0; k < 8; k++) begin
			put_byte(a + k, v[8*k +: 8]);
		end
	endtask

	task automatic load_straight();
		for (int i = 0; i < 40; i++) begin
			put_byte(i, STRAIGHT_PROG[i]);
		end
	endtask

	task automatic do_reset();
		@(posedge clk);
		rst      <= 1'b1;
		stall    <= 1'b0;
		redirect <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		run <= 1'b0; // run from the last test stays up through reset
		accepted = 0;
		seen.delete();
	endtask

	task automatic run_until(input int n, input int limit);
		int c;
		c = 0;
		run <= 1'b1;
		while (accepted < n && c < limit) begin
			@(posedge clk);
			if (stall_en) begin
				stall <= ($urandom_range(0, 1) == 1);
			end
			c++;
		end
		stall <= 1'b0;
		if (accepted < n) begin
			errors++;
			$display("timeout, only %0d of %0d instructions were fetched", accepted, n);
		end
	endtask

	task automatic expect_stopped(input int cycles, input logic [2:0] s);
		repeat (cycles) begin
			@(posedge clk);
			check("f_valid", 64'(f_valid), 64'd0);
			check("stat", 64'(stat), 64'(s));
		end
	endtask

	task automatic check_seen(input int i, input logic [63:0] v);
		if (i < seen.size()) begin
			check("f_pc", seen[i], v);
		end else begin
			errors++;
			$display("instruction %0d was never fetched", i);
		end
	endtask

	task automatic stop_case(input int n, input logic [2:0] s);
		do_reset();
		run_until(n, 50);
		expect_stopped(4, s);
		run <= 1'b0;
	endtask

	task automatic begin_test();
		err_at_start = errors;
		do_reset();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors > err_at_start) begin
			tests_failed++;
			$display("%s: failed, %0d errors", name, errors - err_at_start);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	initial begin
		logic [7:0] q;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = 8'h00;
		run = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = 64'd0;
		stall_en = 1'b0;
		errors = 0;
		checks = 0;
		accepted = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'haa3f));

		begin_test();
		for (int i = 0; i < IMEM_BYTES; i++) begin
			put_byte(i, 8'($urandom));
		end
		for (int i = 0; i < IMEM_BYTES; i++) begin
			wb_access(1'b0, i, 8'h00, q);
			check("wb_dat_r", 64'(q), 64'(img[AW'(i)]));
		end
		end_test("wishbone load and readback");

		begin_test();
		load_straight();
		run_until(9, 100);
		expect_stopped(3, STAT_HLT);
		ref_seq = seen;
		end_test("straight-line fetch");

		begin_test();
		put_byte(0, 8'h70); // jmp 0x20
		put_quad(1, 64'h20);
		put_byte(32'h20, 8'h80); // call 0x40
		put_quad(32'h21, 64'h40);
		put_byte(32'h40, 8'h10);
		put_byte(32'h41, 8'h90); // ret
		put_byte(32'h29, 8'h00); // return address holds halt
		run_until(4, 60);
		expect_stopped(5, STAT_AOK);
		@(posedge clk);
		redirect    <= 1'b1;
		redirect_pc <= 64'h29;
		@(posedge clk);
		redirect <= 1'b0;
		run_until(5, 20);
		check_seen(1, 64'h20);
		check_seen(2, 64'h40);
		check_seen(4, 64'h29);
		end_test("control-flow prediction");

		begin_test();
		load_straight();
		stall_en = 1'b1;
		run_until(9, 400);
		stall_en = 1'b0;
		check("sequence length", 64'(seen.size()), 64'(ref_seq.size()));
		for (int i = 0; i < ref_seq.size(); i++) begin
			check_seen(i, ref_seq[i]);
		end
		end_test("back-pressure");

		begin_test();
		put_byte(0, 8'h00);
		stop_case(1, STAT_HLT);
		put_byte(0, 8'hC0);
		stop_case(1, STAT_INS);
		put_byte(0, 8'h70); // jump past the end of memory
		put_quad(1, 64'h300);
		stop_case(2, STAT_ADR);
		end_test("stopping status");

		begin_test();
		load_straight();
		@(posedge clk);
		stall <= 1'b1;
		run   <= 1'b1;
		repeat (2) @(posedge clk);
		redirect    <= 1'b1;
		redirect_pc <= 64'd38; // the nop
		@(posedge clk);
		redirect <= 1'b0;
		@(posedge clk);
		stall <= 1'b0;
		run_until(2, 50);
		check_seen(0, 64'd38);
		end_test("redirect under stall");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(TEST_CYCLES * 4 * 100);
		$display("watchdog expired, the tests did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+bench
rtl/y86_pkg.sv
rtl/instruction_memory.sv
rtl/fetch_decode.sv
rtl/pc_control.sv
rtl/y86_fetch_top.sv
bench/fetch_clock.sv
bench/fetch_properties.sv
bench/fetch_tb.sv

//--- rtl/fetch_decode.sv
module fetch_decode (
	input  logic [63:0]         pc,
	input  logic [7:0]          byte0,
	input  y86_pkg::tail_bytes  tail,
	input  logic                imem_error,
	output logic [3:0]          icode,
	output logic [3:0]          ifun,
	output logic [3:0]          ra,
	output logic [3:0]          rb,
	output logic [63:0]         valc,
	output logic [63:0]         valp,
	output logic [63:0]         pred_pc,
	output logic [2:0]          instr_stat,
	output logic                is_ret
);

	import y86_pkg::*;

	instr_tail_u view;
	logic        need_regids;
	logic        need_valc;
	logic        legal;
	logic        is_branch;

	assign icode = byte0[7:4];
	assign ifun  = byte0[3:0];
	assign view  = tail;

	always_comb begin
		case (icode)
			I_RRMOVQ, I_IRMOVQ, I_RMMOVQ, I_MRMOVQ,
			I_OPQ, I_PUSHQ, I_POPQ: need_regids = 1'b1;
			default:                need_regids = 1'b0;
		endcase
	end

	always_comb begin
		case (icode)
			I_IRMOVQ, I_RMMOVQ, I_MRMOVQ, I_JXX, I_CALL: need_valc = 1'b1;
			default:                                    need_valc = 1'b0;
		endcase
	end

	always_comb begin
		case (icode)
			I_HALT, I_NOP, I_IRMOVQ, I_RMMOVQ, I_MRMOVQ,
			I_CALL, I_RET, I_PUSHQ, I_POPQ: legal = (ifun == 4'h0);
			I_RRMOVQ, I_JXX:                legal = (ifun <= JXX_FN_MAX); // cmov shares jXX codes
			I_OPQ:                          legal = (ifun <= OPQ_FN_MAX);
			default:                        legal = 1'b0; // C and above
		endcase
	end

	// the tail is read in the view that matches the format
	always_comb begin
		if (need_regids) begin
			ra = view.with_regs.ra;
			rb = view.with_regs.rb;
		end else begin
			ra = F_NONE;
			rb = F_NONE;
		end
		if (!need_valc) begin
			valc = 64'd0;
		end else if (need_regids) begin
			valc = view.with_regs.valc;
		end else begin
			valc = view.dest_only.valc; // jXX and call
		end
	end

	assign valp = pc + 64'd1 + {63'd0, need_regids} + {60'd0, need_valc, 3'd0};

	// taken-branch prediction as in PIPE
	assign is_branch = (icode == I_JXX) || (icode == I_CALL);
	assign pred_pc   = is_branch ? valc : valp;

	always_comb begin
		if (imem_error) begin
			instr_stat = STAT_ADR;
		end else if (!legal) begin
			instr_stat = STAT_INS;
		end else if (icode == I_HALT) begin
			instr_stat = STAT_HLT;
		end else begin
			instr_stat = STAT_AOK;
		end
	end

	assign is_ret = (icode == I_RET) && legal;

endmodule

//--- rtl/instruction_memory.sv
module instruction_memory #(
	parameter int IMEM_BYTES = 2048,
	localparam int AW = $clog2(IMEM_BYTES)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [63:0]         pc,
	output logic [7:0]          byte0,
	output y86_pkg::tail_bytes  tail,
	output logic                imem_error,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [AW-1:0]       wb_adr,
	input  logic [7:0]          wb_dat_w,
	output logic [7:0]          wb_dat_r,
	output logic                wb_ack
);

	logic [7:0] mem [IMEM_BYTES];
	logic       wb_req;

	// zero outside the array, so a tail running off the end stays defined
	function automatic logic [7:0] rd_byte(input logic [63:0] a);
		if (a < 64'(IMEM_BYTES)) begin
			return mem[a[AW-1:0]];
		end
		return 8'h00;
	endfunction

	// new request only while ack is low, gives the one-cycle ack
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_req;
		end
	end

	// write lands on the request edge, read data valid during ack
	always_ff @(posedge clk) begin
		if (wb_req) begin
			if (wb_we) begin
				mem[wb_adr] <= wb_dat_w;
			end
			wb_dat_r <= mem[wb_adr]; // old byte on a write cycle
		end
	end

	assign imem_error = (pc >= 64'(IMEM_BYTES));

	// fetch side has no clock, ten bytes straight from pc
	always_comb begin
		byte0 = rd_byte(pc);
		for (int i = 0; i < 9; i++) begin
			tail[i] = rd_byte(pc + 64'(i + 1));
		end
	end

endmodule

//--- rtl/pc_control.sv
module pc_control #(
	parameter int IMEM_BYTES = 2048
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        run,
	input  logic        stall,
	input  logic        redirect,
	input  logic [63:0] redirect_pc,
	input  logic [63:0] pred_pc,
	input  logic [2:0]  instr_stat,
	input  logic        is_ret,
	output logic [63:0] pc,
	output logic        f_valid,
	output logic [2:0]  stat
);

	import y86_pkg::*;

	logic       ret_wait; // set by a taken ret, cleared by redirect
	logic [2:0] stat_q;   // sticky status
	logic       take;

	// nothing is presented while in reset
	assign f_valid = run && !rst && !ret_wait && (stat_q == STAT_AOK);
	assign take    = f_valid && !stall;
	assign stat    = f_valid ? instr_stat : stat_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= 64'd0;
			ret_wait <= 1'b0;
			stat_q   <= STAT_AOK;
		end else if (redirect) begin
			// redirect wins over stall and squashes this fetch
			pc       <= redirect_pc;
			ret_wait <= 1'b0;
		end else if (take) begin
			if (instr_stat != STAT_AOK) begin
				stat_q <= instr_stat; // stop here and keep pc on the faulting instruction
			end else begin
				pc <= pred_pc;
				if (is_ret) begin
					ret_wait <= 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/y86_fetch_top.sv
module y86_fetch_top #(
	parameter int IMEM_BYTES = 2048,
	localparam int AW = $clog2(IMEM_BYTES)
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  logic [AW-1:0] wb_adr,
	input  logic [7:0]    wb_dat_w,
	output logic [7:0]    wb_dat_r,
	output logic          wb_ack,
	input  logic          run,
	input  logic          stall,
	input  logic          redirect,
	input  logic [63:0]   redirect_pc,
	output logic          f_valid,
	output logic [63:0]   f_pc,
	output logic [3:0]    icode,
	output logic [3:0]    ifun,
	output logic [3:0]    ra,
	output logic [3:0]    rb,
	output logic [63:0]   valc,
	output logic [63:0]   valp,
	output logic [2:0]    stat
);

	import y86_pkg::*;

	logic [7:0]  byte0;
	tail_bytes   tail;
	logic        imem_error;
	logic [63:0] pred_pc;
	logic [2:0]  instr_stat;
	logic        is_ret;

	instruction_memory #(.IMEM_BYTES(IMEM_BYTES)) u_imem (
		.clk        (clk),
		.rst        (rst),
		.pc         (f_pc),
		.byte0      (byte0),
		.tail       (tail),
		.imem_error (imem_error),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack)
	);

	fetch_decode u_decode (
		.pc         (f_pc),
		.byte0      (byte0),
		.tail       (tail),
		.imem_error (imem_error),
		.icode      (icode),
		.ifun       (ifun),
		.ra         (ra),
		.rb         (rb),
		.valc       (valc),
		.valp       (valp),
		.pred_pc    (pred_pc),
		.instr_stat (instr_stat),
		.is_ret     (is_ret)
	);

	// pc register output is the fetch pc seen outside
	pc_control #(.IMEM_BYTES(IMEM_BYTES)) u_pc (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pred_pc     (pred_pc),
		.instr_stat  (instr_stat),
		.is_ret      (is_ret),
		.pc          (f_pc),
		.f_valid     (f_valid),
		.stat        (stat)
	);

endmodule

//--- rtl/y86_pkg.sv
package y86_pkg;

	// instruction codes, high nibble of byte 0
	localparam logic [3:0] I_HALT   = 4'h0;
	localparam logic [3:0] I_NOP    = 4'h1;
	localparam logic [3:0] I_RRMOVQ = 4'h2; // also the cmovXX family
	localparam logic [3:0] I_IRMOVQ = 4'h3;
	localparam logic [3:0] I_RMMOVQ = 4'h4;
	localparam logic [3:0] I_MRMOVQ = 4'h5;
	localparam logic [3:0] I_OPQ    = 4'h6;
	localparam logic [3:0] I_JXX    = 4'h7;
	localparam logic [3:0] I_CALL   = 4'h8;
	localparam logic [3:0] I_RET    = 4'h9;
	localparam logic [3:0] I_PUSHQ  = 4'hA;
	localparam logic [3:0] I_POPQ   = 4'hB;

	// highest legal function codes
	localparam logic [3:0] OPQ_FN_MAX = 4'h3; // addq subq andq xorq
	localparam logic [3:0] JXX_FN_MAX = 4'h6; // jmp jle jl je jne jge jg

	localparam logic [3:0] F_NONE = 4'hF; // no register

	// status codes
	localparam logic [2:0] STAT_AOK = 3'd1;
	localparam logic [2:0] STAT_HLT = 3'd2;
	localparam logic [2:0] STAT_ADR = 3'd3;
	localparam logic [2:0] STAT_INS = 3'd4;

	// bytes pc+1 .. pc+9, byte 0 of the array is pc+1
	typedef logic [8:0][7:0] tail_bytes;

	// register byte at pc+1, constant at pc+2 .. pc+9
	typedef struct packed {
		logic [63:0] valc;
		logic [3:0]  ra;
		logic [3:0]  rb;
	} reg_tail_t;

	// constant right after byte 0, as in jXX and call
	typedef struct packed {
		logic [7:0]  spare; // belongs to the next instruction
		logic [63:0] valc;
	} dest_tail_t;

	typedef union packed {
		reg_tail_t  with_regs;
		dest_tail_t dest_only;
	} instr_tail_u;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f filelist.f -o fetch_sim
out="$(./obj_dir/fetch_sim)"
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
	exit 0
else
	exit 1
fi
